//--- rob_cfg_pkg.sv
// rob configuration: buffer depth, index widths, rename and branch field sizes
`default_nettype none

package rob_cfg_pkg;

	// ------------------------------------------------------------------------
	// buffer geometry
	// ------------------------------------------------------------------------
	localparam int ROB_DEPTH = 32;		// entries in flight
	localparam int ROB_IDX_W = 5;		// slot index
	localparam int ROB_PTR_W = 6;		// slot index plus wrap bit

	// ------------------------------------------------------------------------
	// rename and branch fields
	// ------------------------------------------------------------------------
	localparam int PRF_IDX_W = 6;		// physical register tag
	localparam int LREG_W    = 5;		// logical destination
	localparam int FL_HEAD_W = 5;		// free list head snapshot
	localparam int BR_MASK_W = 4;		// one bit per unresolved branch
	localparam int ADDR_W    = 64;		// branch target address

endpackage

`default_nettype wire

//--- rob_entry_pkg.sv
// rob entry record and branch resolution outcome type
`default_nettype none

package rob_entry_pkg;

	// one reorder buffer slot, written at dispatch
	typedef struct packed {
		logic [rob_cfg_pkg::PRF_IDX_W-1:0]	tag;		// new physical dest
		logic [rob_cfg_pkg::PRF_IDX_W-1:0]	old_tag;	// mapping replaced by this instr
		logic [rob_cfg_pkg::LREG_W-1:0]		lreg;
		logic					br_flag;
		logic					pred_taken;
		logic [rob_cfg_pkg::ADDR_W-1:0]		pred_target;
		logic [rob_cfg_pkg::BR_MASK_W-1:0]	br_mask;
		logic [rob_cfg_pkg::FL_HEAD_W-1:0]	fl_head;	// free list state to restore
	} rob_entry_t;

	// result of comparing a completed branch against its prediction
	typedef enum logic [1:0] {
		BR_NONE  = 2'd0,	// no branch completing
		BR_RIGHT = 2'd1,
		BR_WRONG = 2'd2
	} br_outcome_e;

endpackage

`default_nettype wire

//--- rob_ptr_if.sv
// rob pointer bundle: head and tail positions, retire and flush requests
`timescale 1ns/1ns
`default_nettype none

interface rob_ptr_if;

	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	head_idx;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	tail_idx;
	logic					retire;		// head entry leaves this cycle
	logic					flush;		// mispredict, roll the tail back
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	flush_idx;	// slot of the bad branch

	modport ptr (output head_idx, tail_idx, input retire, flush, flush_idx);
	modport array (input head_idx, tail_idx, flush, flush_idx, output retire);
	modport resolve (output flush, flush_idx);

endinterface

`default_nettype wire

//--- rob_resolve_if.sv
// branch field lookup of one rob entry for the resolution logic
`timescale 1ns/1ns
`default_nettype none

interface rob_resolve_if;

	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	query_idx;
	logic					br_flag;	// only set for a live branch slot
	logic					pred_taken;
	logic [rob_cfg_pkg::ADDR_W-1:0]		pred_target;
	logic [rob_cfg_pkg::BR_MASK_W-1:0]	br_mask;
	logic [rob_cfg_pkg::FL_HEAD_W-1:0]	fl_head;

	modport array (input query_idx,
		output br_flag, pred_taken, pred_target, br_mask, fl_head);
	modport resolve (output query_idx,
		input br_flag, pred_taken, pred_target, br_mask, fl_head);

endinterface

`default_nettype wire

//--- rob_ptr_ctrl.sv
// rob head and tail pointers with wrap bits, full detection and tail rollback
`timescale 1ns/1ns
`default_nettype none

module rob_ptr_ctrl (
	input  wire		clk,
	input  wire		rst,
	input  wire		dispatch_i,
	rob_ptr_if.ptr		ptr,
	output logic		stall_o
);

	logic [rob_cfg_pkg::ROB_PTR_W-1:0]	head_r;
	logic [rob_cfg_pkg::ROB_PTR_W-1:0]	tail_r;
	logic [rob_cfg_pkg::ROB_PTR_W-1:0]	occ;		// entries in flight, 0..32
	logic [rob_cfg_pkg::ROB_PTR_W-1:0]	flush_ptr;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	flush_off;	// branch distance from head
	logic					full;
	logic					flush_wrap;

	assign occ  = tail_r - head_r;
	assign full = occ[rob_cfg_pkg::ROB_PTR_W-1];	// only set at exactly 32

	// a retiring head frees a slot in time for this cycle's dispatch
	assign stall_o = full & ~ptr.retire;

	assign ptr.head_idx = head_r[rob_cfg_pkg::ROB_IDX_W-1:0];
	assign ptr.tail_idx = tail_r[rob_cfg_pkg::ROB_IDX_W-1:0];

	// ------------------------------------------------------------------------
	// rollback target
	// ------------------------------------------------------------------------
	// the branch lies in the head's lap if its index is not below the head,
	// otherwise the live range has wrapped and it sits one lap further
	assign flush_wrap = (ptr.flush_idx >= ptr.head_idx) ?
		head_r[rob_cfg_pkg::ROB_PTR_W-1] : ~head_r[rob_cfg_pkg::ROB_PTR_W-1];
	assign flush_ptr  = {flush_wrap, ptr.flush_idx};
	assign flush_off  = ptr.flush_idx - ptr.head_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
		end else begin
			if (ptr.retire)
				head_r <= head_r + 1'b1;
			if (ptr.flush)
				tail_r <= flush_ptr + 1'b1;	// carry moves into the wrap bit
			else if (dispatch_i)
				tail_r <= tail_r + 1'b1;
		end
	end

	// source must honour stall_o
	a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
		dispatch_i |-> !(full && !ptr.retire))
		else $error("rob dispatch while full");

	// mispredicted branch must be a live entry
	a_flush_in_range: assert property (@(posedge clk) disable iff (rst)
		ptr.flush |-> ({1'b0, flush_off} < occ))
		else $error("rob flush index outside head..tail");

endmodule

`default_nettype wire

//--- rob_entry_array.sv
// rob entry storage: tail write, completion marking, head retire and branch lookup
`timescale 1ns/1ns
`default_nettype none

module rob_entry_array (
	input  wire					clk,
	input  wire					rst,
	input  wire					dispatch_i,
	input  rob_entry_pkg::rob_entry_t		dp_entry_i,
	input  wire					fu_done_i,
	input  wire [rob_cfg_pkg::ROB_IDX_W-1:0]	fu_idx_i,
	rob_ptr_if.array				ptr,
	rob_resolve_if.array				rsv,
	output logic					retire_o,
	output logic [rob_cfg_pkg::PRF_IDX_W-1:0]	retire_tag_o,
	output logic [rob_cfg_pkg::PRF_IDX_W-1:0]	retire_old_tag_o,
	output logic [rob_cfg_pkg::LREG_W-1:0]		retire_lreg_o
);

	rob_entry_pkg::rob_entry_t		entries_r [rob_cfg_pkg::ROB_DEPTH];
	rob_entry_pkg::rob_entry_t		head_entry;
	rob_entry_pkg::rob_entry_t		query_entry;

	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	valid_r;
	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	done_r;
	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	dp_set;		// slot being allocated
	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	done_set;	// slot being completed
	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	ret_clr;	// slot being retired
	logic [rob_cfg_pkg::ROB_DEPTH-1:0]	kill_mask;	// younger than a bad branch
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	young_cnt;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]	slot_off;
	logic					dp_we;

	// a dispatch in a recovery cycle is dropped
	assign dp_we = dispatch_i & ~ptr.flush;

	// ------------------------------------------------------------------------
	// head side
	// ------------------------------------------------------------------------
	assign head_entry = entries_r[ptr.head_idx];
	assign retire_o   = valid_r[ptr.head_idx] & done_r[ptr.head_idx];
	assign ptr.retire = retire_o;

	assign retire_tag_o     = retire_o ? head_entry.tag : '0;
	assign retire_old_tag_o = retire_o ? head_entry.old_tag : '0;
	assign retire_lreg_o    = retire_o ? head_entry.lreg : '0;

	// ------------------------------------------------------------------------
	// per slot update strobes
	// ------------------------------------------------------------------------
	// live slots younger than the branch run from flush_idx+1 up to tail-1
	assign young_cnt = ptr.tail_idx - ptr.flush_idx - 1'b1;

	always_comb begin
		dp_set    = '0;
		done_set  = '0;
		ret_clr   = '0;
		kill_mask = '0;
		slot_off  = '0;
		for (int i = 0; i < rob_cfg_pkg::ROB_DEPTH; i++) begin
			slot_off     = i[rob_cfg_pkg::ROB_IDX_W-1:0] - ptr.flush_idx - 1'b1;
			dp_set[i]    = dp_we && (i[rob_cfg_pkg::ROB_IDX_W-1:0] == ptr.tail_idx);
			done_set[i]  = fu_done_i && (i[rob_cfg_pkg::ROB_IDX_W-1:0] == fu_idx_i);
			ret_clr[i]   = retire_o && (i[rob_cfg_pkg::ROB_IDX_W-1:0] == ptr.head_idx);
			kill_mask[i] = ptr.flush && (slot_off < young_cnt);
		end
	end

	// full buffer with retire and dispatch hits one slot, so the new entry wins
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_r <= '0;
			done_r  <= '0;
		end else begin
			valid_r <= (valid_r & ~kill_mask & ~ret_clr) | dp_set;
			done_r  <= ((done_r & ~dp_set) | done_set) & ~kill_mask & ~ret_clr;
		end
	end

	always_ff @(posedge clk) begin
		if (dp_we)
			entries_r[ptr.tail_idx] <= dp_entry_i;
	end

	// ------------------------------------------------------------------------
	// branch lookup for the resolution logic
	// ------------------------------------------------------------------------
	assign query_entry     = entries_r[rsv.query_idx];
	assign rsv.br_flag     = valid_r[rsv.query_idx] & query_entry.br_flag;
	assign rsv.pred_taken  = query_entry.pred_taken;
	assign rsv.pred_target = query_entry.pred_target;
	assign rsv.br_mask     = query_entry.br_mask;
	assign rsv.fl_head     = query_entry.fl_head;

	// functional units only finish instructions that are still in flight
	a_done_live: assert property (@(posedge clk) disable iff (rst)
		fu_done_i |-> valid_r[fu_idx_i])
		else $error("rob completion on empty slot %0d", fu_idx_i);

endmodule

`default_nettype wire

//--- rob_resolve.sv
// rob branch resolution: checks outcome against prediction, drives early recovery
`timescale 1ns/1ns
`default_nettype none

module rob_resolve (
	input  wire					fu_done_i,
	input  wire [rob_cfg_pkg::ROB_IDX_W-1:0]	fu_idx_i,
	input  wire					fu_br_taken_i,
	input  wire [rob_cfg_pkg::ADDR_W-1:0]		fu_br_target_i,
	rob_resolve_if.resolve				rsv,
	rob_ptr_if.resolve				ptr,
	output logic					recover_o,
	output logic					br_right_o,
	output logic [rob_cfg_pkg::BR_MASK_W-1:0]	recover_mask_o,
	output logic [rob_cfg_pkg::FL_HEAD_W-1:0]	recover_fl_head_o
);

	rob_entry_pkg::br_outcome_e	outcome;
	logic				mismatch;

	assign rsv.query_idx = fu_idx_i;	// look up the completing entry

	// direction or target wrong counts as a mispredict
	assign mismatch = (fu_br_taken_i != rsv.pred_taken) |
		(fu_br_target_i != rsv.pred_target);

	always_comb begin
		if (!(fu_done_i && rsv.br_flag))
			outcome = rob_entry_pkg::BR_NONE;
		else if (mismatch)
			outcome = rob_entry_pkg::BR_WRONG;
		else
			outcome = rob_entry_pkg::BR_RIGHT;
	end

	assign recover_o  = (outcome == rob_entry_pkg::BR_WRONG);
	assign br_right_o = (outcome == rob_entry_pkg::BR_RIGHT);

	// squash state only leaves on a mispredict
	assign recover_mask_o    = recover_o ? rsv.br_mask : '0;
	assign recover_fl_head_o = recover_o ? rsv.fl_head : '0;

	assign ptr.flush     = recover_o;
	assign ptr.flush_idx = recover_o ? fu_idx_i : '0;

endmodule

`default_nettype wire

//--- rob_top.sv
// reorder buffer top: pointer control, entry array and branch resolution
`timescale 1ns/1ns
`default_nettype none

module rob_top (
	input  wire					clk,
	input  wire					rst,

	// ------------------------------------------------------------------------
	// dispatch
	// ------------------------------------------------------------------------
	input  wire					dispatch_i,
	input  wire [rob_cfg_pkg::PRF_IDX_W-1:0]	dp_tag_i,
	input  wire [rob_cfg_pkg::PRF_IDX_W-1:0]	dp_old_tag_i,
	input  wire [rob_cfg_pkg::LREG_W-1:0]		dp_lreg_i,
	input  wire					dp_br_flag_i,
	input  wire					dp_pred_taken_i,
	input  wire [rob_cfg_pkg::ADDR_W-1:0]		dp_pred_target_i,
	input  wire [rob_cfg_pkg::BR_MASK_W-1:0]	dp_br_mask_i,
	input  wire [rob_cfg_pkg::FL_HEAD_W-1:0]	dp_fl_head_i,

	// ------------------------------------------------------------------------
	// completion
	// ------------------------------------------------------------------------
	input  wire					fu_done_i,
	input  wire [rob_cfg_pkg::ROB_IDX_W-1:0]	fu_idx_i,
	input  wire					fu_br_taken_i,
	input  wire [rob_cfg_pkg::ADDR_W-1:0]		fu_br_target_i,

	output logic					stall_o,
	output logic [rob_cfg_pkg::ROB_IDX_W-1:0]	tail_idx_o,	// slot for next dispatch
	output logic					retire_o,
	output logic [rob_cfg_pkg::PRF_IDX_W-1:0]	retire_tag_o,
	output logic [rob_cfg_pkg::PRF_IDX_W-1:0]	retire_old_tag_o,
	output logic [rob_cfg_pkg::LREG_W-1:0]		retire_lreg_o,
	output logic					recover_o,
	output logic					br_right_o,
	output logic [rob_cfg_pkg::BR_MASK_W-1:0]	recover_mask_o,
	output logic [rob_cfg_pkg::FL_HEAD_W-1:0]	recover_fl_head_o
);

	rob_entry_pkg::rob_entry_t	dp_entry;

	rob_ptr_if	ptr_if ();
	rob_resolve_if	rsv_if ();

	assign dp_entry = '{
		tag:         dp_tag_i,
		old_tag:     dp_old_tag_i,
		lreg:        dp_lreg_i,
		br_flag:     dp_br_flag_i,
		pred_taken:  dp_pred_taken_i,
		pred_target: dp_pred_target_i,
		br_mask:     dp_br_mask_i,
		fl_head:     dp_fl_head_i
	};

	assign tail_idx_o = ptr_if.tail_idx;

	rob_ptr_ctrl u_ptr_ctrl (
		.clk		(clk),
		.rst		(rst),
		.dispatch_i	(dispatch_i),
		.ptr		(ptr_if.ptr),
		.stall_o	(stall_o)
	);

	rob_entry_array u_entry_array (
		.clk			(clk),
		.rst			(rst),
		.dispatch_i		(dispatch_i),
		.dp_entry_i		(dp_entry),
		.fu_done_i		(fu_done_i),
		.fu_idx_i		(fu_idx_i),
		.ptr			(ptr_if.array),
		.rsv			(rsv_if.array),
		.retire_o		(retire_o),
		.retire_tag_o		(retire_tag_o),
		.retire_old_tag_o	(retire_old_tag_o),
		.retire_lreg_o		(retire_lreg_o)
	);

	rob_resolve u_resolve (
		.fu_done_i		(fu_done_i),
		.fu_idx_i		(fu_idx_i),
		.fu_br_taken_i		(fu_br_taken_i),
		.fu_br_target_i		(fu_br_target_i),
		.rsv			(rsv_if.resolve),
		.ptr			(ptr_if.resolve),
		.recover_o		(recover_o),
		.br_right_o		(br_right_o),
		.recover_mask_o		(recover_mask_o),
		.recover_fl_head_o	(recover_fl_head_o)
	);

endmodule

`default_nettype wire

//--- tb_rob.sv
// reorder buffer testbench with a queue model, concurrent output checks and a watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_rob;

	localparam int N_RAND  = 200;				// random phase dispatches
	localparam int N_INSTR = N_RAND + 40;			// all tests together
	localparam int TIMEOUT = N_INSTR * 40 + 2000;		// cycles

	typedef struct packed {
		rob_entry_pkg::rob_entry_t		ent;
		logic					done;
		logic [rob_cfg_pkg::ROB_IDX_W-1:0]	slot;
	} model_t;

	logic						clk;
	logic						rst = 1'b1;
	logic						dispatch_i = 1'b0;
	rob_entry_pkg::rob_entry_t			dp_ent = '0;
	logic						fu_done_i = 1'b0;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]		fu_idx_i = '0;
	logic						fu_br_taken_i = 1'b0;
	logic [rob_cfg_pkg::ADDR_W-1:0]		fu_br_target_i = '0;
	logic						stall_o, retire_o, recover_o, br_right_o;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]		tail_idx_o;
	logic [rob_cfg_pkg::PRF_IDX_W-1:0]		retire_tag_o, retire_old_tag_o;
	logic [rob_cfg_pkg::LREG_W-1:0]		retire_lreg_o;
	logic [rob_cfg_pkg::BR_MASK_W-1:0]		recover_mask_o;
	logic [rob_cfg_pkg::FL_HEAD_W-1:0]		recover_fl_head_o;

	// expected outputs for the current cycle are updated together with the inputs
	rob_entry_pkg::br_outcome_e			exp_outcome = rob_entry_pkg::BR_NONE;
	logic						exp_stall = 1'b0;
	logic						exp_retire = 1'b0;
	logic [rob_cfg_pkg::PRF_IDX_W-1:0]		exp_tag = '0;
	logic [rob_cfg_pkg::PRF_IDX_W-1:0]		exp_old_tag = '0;
	logic [rob_cfg_pkg::LREG_W-1:0]		exp_lreg = '0;
	logic [rob_cfg_pkg::BR_MASK_W-1:0]		exp_mask = '0;
	logic [rob_cfg_pkg::FL_HEAD_W-1:0]		exp_fl_head = '0;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]		exp_tail = '0;
	logic						exp_recover, exp_right;

	// inputs applied in the current cycle and consumed by the model at the next edge
	logic						cur_dp = 1'b0;
	rob_entry_pkg::rob_entry_t			cur_ent = '0;
	logic						cur_done = 1'b0;
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]		cur_idx = '0;
	logic						cur_taken = 1'b0;
	logic [rob_cfg_pkg::ADDR_W-1:0]		cur_target = '0;

	model_t						model_q [$];	// oldest first
	logic [rob_cfg_pkg::ROB_IDX_W-1:0]		model_tail = '0;
	int						errors = 0;

	assign exp_recover = (exp_outcome == rob_entry_pkg::BR_WRONG);
	assign exp_right   = (exp_outcome == rob_entry_pkg::BR_RIGHT);

	rob_top u_dut (
		.clk			(clk),
		.rst			(rst),
		.dispatch_i		(dispatch_i),
		.dp_tag_i		(dp_ent.tag),
		.dp_old_tag_i		(dp_ent.old_tag),
		.dp_lreg_i		(dp_ent.lreg),
		.dp_br_flag_i		(dp_ent.br_flag),
		.dp_pred_taken_i	(dp_ent.pred_taken),
		.dp_pred_target_i	(dp_ent.pred_target),
		.dp_br_mask_i		(dp_ent.br_mask),
		.dp_fl_head_i		(dp_ent.fl_head),
		.fu_done_i		(fu_done_i),
		.fu_idx_i		(fu_idx_i),
		.fu_br_taken_i		(fu_br_taken_i),
		.fu_br_target_i		(fu_br_target_i),
		.stall_o		(stall_o),
		.tail_idx_o		(tail_idx_o),
		.retire_o		(retire_o),
		.retire_tag_o		(retire_tag_o),
		.retire_old_tag_o	(retire_old_tag_o),
		.retire_lreg_o		(retire_lreg_o),
		.recover_o		(recover_o),
		.br_right_o		(br_right_o),
		.recover_mask_o		(recover_mask_o),
		.recover_fl_head_o	(recover_fl_head_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_value(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		errors++;
		$display("** Error: %s expected %0h, got %0h at %0t", name, exp_v, act_v, $time);
	endtask

	// ------------------------------------------------------------------------
	// output checks
	// ------------------------------------------------------------------------
	a_reset_tail: assert property (@(posedge clk) $fell(rst) |-> tail_idx_o == '0)
		else report_value("tail_idx_o after reset", 64'h0, 64'($sampled(tail_idx_o)));
	a_reset_flags: assert property (@(posedge clk) $fell(rst) |->
		{stall_o, retire_o, recover_o, br_right_o} == 4'h0)
		else report_value("{stall_o,retire_o,recover_o,br_right_o} after reset", 64'h0,
			64'($sampled({stall_o, retire_o, recover_o, br_right_o})));

	a_stall: assert property (@(posedge clk) disable iff (rst) stall_o == exp_stall)
		else report_value("stall_o", 64'($sampled(exp_stall)), 64'($sampled(stall_o)));
	a_tail: assert property (@(posedge clk) disable iff (rst) tail_idx_o == exp_tail)
		else report_value("tail_idx_o", 64'($sampled(exp_tail)), 64'($sampled(tail_idx_o)));
	a_retire: assert property (@(posedge clk) disable iff (rst) retire_o == exp_retire)
		else report_value("retire_o", 64'($sampled(exp_retire)), 64'($sampled(retire_o)));
	a_ret_tag: assert property (@(posedge clk) disable iff (rst)
		exp_retire |-> retire_tag_o == exp_tag)
		else report_value("retire_tag_o", 64'($sampled(exp_tag)),
			64'($sampled(retire_tag_o)));
	a_ret_old: assert property (@(posedge clk) disable iff (rst)
		exp_retire |-> retire_old_tag_o == exp_old_tag)
		else report_value("retire_old_tag_o", 64'($sampled(exp_old_tag)),
			64'($sampled(retire_old_tag_o)));
	a_ret_lreg: assert property (@(posedge clk) disable iff (rst)
		exp_retire |-> retire_lreg_o == exp_lreg)
		else report_value("retire_lreg_o", 64'($sampled(exp_lreg)),
			64'($sampled(retire_lreg_o)));
	a_recover: assert property (@(posedge clk) disable iff (rst) recover_o == exp_recover)
		else report_value("recover_o", 64'($sampled(exp_recover)),
			64'($sampled(recover_o)));
	a_br_right: assert property (@(posedge clk) disable iff (rst) br_right_o == exp_right)
		else report_value("br_right_o", 64'($sampled(exp_right)),
			64'($sampled(br_right_o)));
	a_rec_mask: assert property (@(posedge clk) disable iff (rst) recover_mask_o == exp_mask)
		else report_value("recover_mask_o", 64'($sampled(exp_mask)),
			64'($sampled(recover_mask_o)));
	a_rec_fl: assert property (@(posedge clk) disable iff (rst)
		recover_fl_head_o == exp_fl_head)
		else report_value("recover_fl_head_o", 64'($sampled(exp_fl_head)),
			64'($sampled(recover_fl_head_o)));

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic int find_slot(input logic [rob_cfg_pkg::ROB_IDX_W-1:0] slot);
		for (int i = 0; i < model_q.size(); i++)
			if (model_q[i].slot == slot)
				return i;
		return -1;
	endfunction

	// a slot is free or the head leaves in this cycle
	function automatic logic can_dispatch();
		return (model_q.size() < rob_cfg_pkg::ROB_DEPTH) || model_q[0].done;
	endfunction

	function automatic rob_entry_pkg::br_outcome_e outcome_of(
			input rob_entry_pkg::rob_entry_t e, input logic taken,
			input logic [rob_cfg_pkg::ADDR_W-1:0] target);
		if (!e.br_flag)
			return rob_entry_pkg::BR_NONE;
		if (taken != e.pred_taken || target != e.pred_target)
			return rob_entry_pkg::BR_WRONG;
		return rob_entry_pkg::BR_RIGHT;
	endfunction

	// random position among the entries still waiting for completion or -1 if none
	function automatic int pick_pending();
		int cnt;
		int k;
		cnt = 0;
		for (int i = 0; i < model_q.size(); i++)
			if (!model_q[i].done)
				cnt++;
		if (cnt == 0)
			return -1;
		k = $urandom % cnt;
		for (int i = 0; i < model_q.size(); i++) begin
			if (!model_q[i].done) begin
				if (k == 0)
					return i;
				k--;
			end
		end
		return -1;
	endfunction

	function automatic rob_entry_pkg::rob_entry_t make_entry(input logic br);
		rob_entry_pkg::rob_entry_t e;
		logic [31:0] r;
		r = $urandom;
		e.tag = r[rob_cfg_pkg::PRF_IDX_W-1:0];
		r = $urandom;
		e.old_tag = r[rob_cfg_pkg::PRF_IDX_W-1:0];
		r = $urandom;
		e.lreg = r[rob_cfg_pkg::LREG_W-1:0];
		r = $urandom;
		e.br_mask = r[rob_cfg_pkg::BR_MASK_W-1:0];
		r = $urandom;
		e.fl_head = r[rob_cfg_pkg::FL_HEAD_W-1:0];
		r = $urandom;
		e.pred_taken = r[0];
		e.pred_target = {$urandom, $urandom};
		e.br_flag = br;
		return e;
	endfunction

	// wait for the edge and apply what the DUT consumed at it
	task automatic advance();
		model_t m;
		int pos;
		logic ret;
		logic rec;
		@(posedge clk);
		ret = (model_q.size() > 0) && model_q[0].done;
		rec = 1'b0;
		pos = find_slot(cur_idx);
		if (cur_done && pos >= 0) begin
			m = model_q[pos];
			rec = (outcome_of(m.ent, cur_taken, cur_target) == rob_entry_pkg::BR_WRONG);
			m.done = 1'b1;
			model_q[pos] = m;
			while (rec && model_q.size() > pos + 1)
				model_q.delete(model_q.size() - 1);	// younger than the branch
		end
		if (ret)
			model_q.delete(0);
		if (rec) begin
			model_tail = cur_idx + 1'b1;			// dispatch of this cycle is lost
		end else if (cur_dp) begin
			m.ent  = cur_ent;
			m.done = 1'b0;
			m.slot = model_tail;
			model_q.push_back(m);
			model_tail = model_tail + 1'b1;
		end
	endtask

	// drive the inputs for the coming cycle and the outputs expected in it
	task automatic apply(input logic d, input rob_entry_pkg::rob_entry_t e, input logic fd,
			input logic [rob_cfg_pkg::ROB_IDX_W-1:0] fi, input logic tk,
			input logic [rob_cfg_pkg::ADDR_W-1:0] tg);
		int pos;
		rob_entry_pkg::br_outcome_e oc;
		cur_dp = d;
		cur_ent = e;
		cur_done = fd;
		cur_idx = fi;
		cur_taken = tk;
		cur_target = tg;
		dispatch_i <= d;
		dp_ent <= e;
		fu_done_i <= fd;
		fu_idx_i <= fi;
		fu_br_taken_i <= tk;
		fu_br_target_i <= tg;
		oc = rob_entry_pkg::BR_NONE;
		pos = find_slot(fi);
		if (fd && pos >= 0)
			oc = outcome_of(model_q[pos].ent, tk, tg);
		exp_outcome <= oc;
		exp_mask <= '0;
		exp_fl_head <= '0;
		if (oc == rob_entry_pkg::BR_WRONG) begin
			exp_mask <= model_q[pos].ent.br_mask;
			exp_fl_head <= model_q[pos].ent.fl_head;
		end
		exp_retire <= 1'b0;
		exp_stall <= 1'b0;
		if (model_q.size() > 0) begin
			exp_retire <= model_q[0].done;
			exp_tag <= model_q[0].ent.tag;
			exp_old_tag <= model_q[0].ent.old_tag;
			exp_lreg <= model_q[0].ent.lreg;
			exp_stall <= (model_q.size() == rob_cfg_pkg::ROB_DEPTH) && !model_q[0].done;
		end
		exp_tail <= model_tail;
	endtask

	// ------------------------------------------------------------------------
	// stimulus helpers of one clock cycle or more
	// ------------------------------------------------------------------------
	// optional dispatch plus completion of the model entry at pos
	task automatic issue(input logic d, input rob_entry_pkg::rob_entry_t e, input int pos,
			input logic wrong);
		logic tk;
		logic [rob_cfg_pkg::ADDR_W-1:0] tg;
		if (pos < 0) begin
			apply(d, e, 1'b0, '0, 1'b0, '0);
		end else begin
			tk = model_q[pos].ent.pred_taken;
			tg = model_q[pos].ent.pred_target;
			if (wrong && $urandom % 2 == 0)
				tk = ~tk;
			else if (wrong)
				tg[0] = ~tg[0];			// target only mispredict
			apply(d, e, 1'b1, model_q[pos].slot, tk, tg);
		end
	endtask

	task automatic end_reset();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic idle_cycle();
		advance();
		issue(1'b0, '0, -1, 1'b0);
	endtask

	task automatic dispatch_entry(input rob_entry_pkg::rob_entry_t e,
			output logic [rob_cfg_pkg::ROB_IDX_W-1:0] slot);
		advance();
		while (!can_dispatch()) begin
			issue(1'b0, '0, -1, 1'b0);
			advance();
		end
		slot = model_tail;
		issue(1'b1, e, -1, 1'b0);
	endtask

	task automatic complete_slot(input logic [rob_cfg_pkg::ROB_IDX_W-1:0] slot,
			input logic wrong);
		advance();
		issue(1'b0, '0, find_slot(slot), wrong);
	endtask

	task automatic random_cycle(inout int left);
		rob_entry_pkg::rob_entry_t e;
		logic d;
		int pos;
		advance();
		d = 1'b0;
		e = '0;
		if (left > 0 && can_dispatch() && ($urandom % 100) < 60) begin
			d = 1'b1;
			e = make_entry(($urandom % 100) < 30);
			left--;
		end
		pos = pick_pending();
		if ($urandom % 2 == 0)
			pos = -1;
		issue(d, e, pos, ($urandom % 100) < 25);
	endtask

	// complete everything left with branches as predicted until the model is empty
	task automatic drain();
		advance();
		while (model_q.size() > 0) begin
			issue(1'b0, '0, pick_pending(), 1'b0);
			advance();
		end
		issue(1'b0, '0, -1, 1'b0);
	endtask

	initial begin
		logic [rob_cfg_pkg::ROB_IDX_W-1:0] s0, s_br, s2, s3;
		int left;
		void'($urandom(87238));
		end_reset();
		repeat (3) idle_cycle();

		// fill all 32 slots and then free the head in the cycle a new entry arrives
		for (int i = 0; i < rob_cfg_pkg::ROB_DEPTH; i++)
			dispatch_entry(make_entry(1'b0), s0);
		repeat (3) idle_cycle();
		complete_slot(model_q[0].slot, 1'b0);
		dispatch_entry(make_entry(1'b0), s0);
		drain();

		// branch resolved as predicted
		dispatch_entry(make_entry(1'b0), s0);
		dispatch_entry(make_entry(1'b1), s_br);
		dispatch_entry(make_entry(1'b0), s2);
		complete_slot(s_br, 1'b0);
		drain();

		// mispredict with a younger entry already done
		dispatch_entry(make_entry(1'b0), s0);
		dispatch_entry(make_entry(1'b1), s_br);
		dispatch_entry(make_entry(1'b0), s2);
		dispatch_entry(make_entry(1'b0), s3);
		complete_slot(s2, 1'b0);
		complete_slot(s_br, 1'b1);
		complete_slot(s0, 1'b0);
		drain();

		left = N_RAND;
		while (left > 0)
			random_cycle(left);
		drain();
		repeat (3) idle_cycle();
		@(negedge clk);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog
	initial begin
		repeat (TIMEOUT) @(posedge clk);
		$display("timeout: run still going after %0d cycles", TIMEOUT);
		$display("errors: %0d", errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
rob_cfg_pkg.sv
rob_entry_pkg.sv
rob_ptr_if.sv
rob_resolve_if.sv
rob_ptr_ctrl.sv
rob_entry_array.sv
rob_resolve.sv
rob_top.sv
tb_rob.sv

//--- run.sh
#!/bin/sh
# compile and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rob -f all.f -o tb_rob_sim
./obj_dir/tb_rob_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
	exit 0
else
	exit 1
fi
